// File: logic/axi_pkg.sv
`default_nettype none

package axi_pkg;

  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_strb_t;
  typedef logic [3:0]  axi_id_t;
  // Master prefix on top of the master ID
  typedef logic [7:0]  axi_ids_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [2:0]  axi_size_t;
  typedef logic [1:0]  axi_burst_t;
  typedef logic [1:0]  axi_resp_t;

  localparam axi_burst_t BURST_FIXED = 2'b00;
  localparam axi_burst_t BURST_INCR  = 2'b01;
  localparam axi_burst_t BURST_WRAP  = 2'b10;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;
  localparam axi_resp_t RESP_DECERR = 2'b11;

  localparam axi_id_t AXI_MASTER_1_ID = 4'b0001;

  // 4 KiB windows
  localparam axi_addr_t SLAVE0_BASE = 32'h0000_0000;
  localparam axi_addr_t SLAVE1_BASE = 32'h0000_1000;

  typedef enum logic [1:0] {SLAVE_0, SLAVE_1, SLAVE_2} addr_dec_result_t;

  typedef enum logic {LOCK_FREE, LOCK_M1} addr_arb_lock_t;

  typedef enum logic [1:0] {BANK_IDLE, BANK_DATA, BANK_RESP} bank_state_t;

  // Anything outside both windows goes to the default slave
  function automatic addr_dec_result_t addr_decode(axi_addr_t addr);
    if (addr[31:12] == SLAVE0_BASE[31:12]) begin
      return SLAVE_0;
    end
    if (addr[31:12] == SLAVE1_BASE[31:12]) begin
      return SLAVE_1;
    end
    return SLAVE_2;
  endfunction

endpackage

`default_nettype wire

// File: logic/aw_router.sv
`timescale 1ns/1ps
`default_nettype none

module aw_router (
  input  logic                      clk,
  input  logic                      rstn,
  input  axi_pkg::axi_id_t          aw_id,
  input  axi_pkg::axi_addr_t        aw_addr,
  input  axi_pkg::axi_len_t         aw_len,
  input  axi_pkg::axi_size_t        aw_size,
  input  axi_pkg::axi_burst_t       aw_burst,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  input  logic                      b_done,
  input  logic                      awready_s0,
  input  logic                      awready_s1,
  input  logic                      awready_s2,
  output axi_pkg::axi_ids_t         awid_s0,
  output axi_pkg::axi_addr_t        awaddr_s0,
  output axi_pkg::axi_len_t         awlen_s0,
  output axi_pkg::axi_size_t        awsize_s0,
  output axi_pkg::axi_burst_t       awburst_s0,
  output logic                      awvalid_s0,
  output axi_pkg::axi_ids_t         awid_s1,
  output axi_pkg::axi_addr_t        awaddr_s1,
  output axi_pkg::axi_len_t         awlen_s1,
  output axi_pkg::axi_size_t        awsize_s1,
  output axi_pkg::axi_burst_t       awburst_s1,
  output logic                      awvalid_s1,
  output axi_pkg::axi_ids_t         awid_s2,
  output axi_pkg::axi_addr_t        awaddr_s2,
  output axi_pkg::axi_len_t         awlen_s2,
  output axi_pkg::axi_size_t        awsize_s2,
  output axi_pkg::axi_burst_t       awburst_s2,
  output logic                      awvalid_s2,
  output axi_pkg::addr_dec_result_t aw_sel,
  output logic                      aw_fire
);

  axi_pkg::addr_arb_lock_t lock_state;
  axi_pkg::addr_arb_lock_t lock_next;
  axi_pkg::axi_ids_t       awid_m;
  logic                    req_valid;
  logic                    slave_ready;
  logic                    lock_q;

  assign awid_m  = {axi_pkg::AXI_MASTER_1_ID, aw_id};
  assign aw_sel  = axi_pkg::addr_decode(aw_addr);
  assign aw_fire = req_valid & slave_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_state <= axi_pkg::LOCK_FREE;
    end else begin
      lock_state <= lock_next;
    end
  end

  // Hold the request until the selected slave takes it
  always_comb begin
    case (lock_state)
      axi_pkg::LOCK_FREE: lock_next = (aw_valid && !lock_q && !aw_fire) ?
                                      axi_pkg::LOCK_M1 : axi_pkg::LOCK_FREE;
      axi_pkg::LOCK_M1:   lock_next = aw_fire ? axi_pkg::LOCK_FREE : axi_pkg::LOCK_M1;
      default:            lock_next = axi_pkg::LOCK_FREE;
    endcase
  end

  // Blocks new addresses while a write waits for its response
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_q <= 1'b0;
    end else if (lock_q) begin
      lock_q <= ~b_done;
    end else begin
      lock_q <= aw_fire;
    end
  end

  always_comb begin
    req_valid = 1'b0;
    aw_ready  = 1'b0;
    case (lock_state)
      axi_pkg::LOCK_FREE: begin
        if (aw_valid && !lock_q) begin
          req_valid = 1'b1;
          aw_ready  = slave_ready;
        end
      end
      // Locked request stays granted until the slave takes it
      axi_pkg::LOCK_M1: begin
        req_valid = 1'b1;
        aw_ready  = slave_ready;
      end
      default: ;
    endcase
  end

  // Fan-out, idle slaves see zeros
  always_comb begin
    {awid_s0, awid_s1, awid_s2}       = '0;
    {awaddr_s0, awaddr_s1, awaddr_s2} = '0;
    {awlen_s0, awlen_s1, awlen_s2}    = '0;
    {awsize_s0, awsize_s1, awsize_s2} = '0;
    {awburst_s0, awburst_s1, awburst_s2} = '0;
    {awvalid_s0, awvalid_s1, awvalid_s2} = '0;
    slave_ready = 1'b0;
    case (aw_sel)
      axi_pkg::SLAVE_0: begin
        {awid_s0, awaddr_s0, awlen_s0} = {awid_m, aw_addr, aw_len};
        {awsize_s0, awburst_s0, awvalid_s0} = {aw_size, aw_burst, req_valid};
        slave_ready = awready_s0;
      end
      axi_pkg::SLAVE_1: begin
        {awid_s1, awaddr_s1, awlen_s1} = {awid_m, aw_addr, aw_len};
        {awsize_s1, awburst_s1, awvalid_s1} = {aw_size, aw_burst, req_valid};
        slave_ready = awready_s1;
      end
      default: begin
        {awid_s2, awaddr_s2, awlen_s2} = {awid_m, aw_addr, aw_len};
        {awsize_s2, awburst_s2, awvalid_s2} = {aw_size, aw_burst, req_valid};
        slave_ready = awready_s2;
      end
    endcase
  end

  a_aw_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
    aw_valid && !aw_ready |=> aw_valid);

endmodule

`default_nettype wire

// File: logic/wb_router.sv
`timescale 1ns/1ps
`default_nettype none

module wb_router (
  input  logic                      clk,
  input  logic                      rstn,
  input  axi_pkg::addr_dec_result_t aw_sel,
  input  logic                      aw_fire,
  input  axi_pkg::axi_data_t        w_data,
  input  axi_pkg::axi_strb_t        w_strb,
  input  logic                      w_last,
  input  logic                      w_valid,
  output logic                      w_ready,
  output axi_pkg::axi_id_t          b_id,
  output axi_pkg::axi_resp_t        b_resp,
  output logic                      b_valid,
  input  logic                      b_ready,
  output logic                      b_done,
  output axi_pkg::axi_data_t        wdata_s0,
  output axi_pkg::axi_strb_t        wstrb_s0,
  output logic                      wlast_s0,
  output logic                      wvalid_s0,
  input  logic                      wready_s0,
  input  axi_pkg::axi_ids_t         bid_s0,
  input  axi_pkg::axi_resp_t        bresp_s0,
  input  logic                      bvalid_s0,
  output logic                      bready_s0,
  output axi_pkg::axi_data_t        wdata_s1,
  output axi_pkg::axi_strb_t        wstrb_s1,
  output logic                      wlast_s1,
  output logic                      wvalid_s1,
  input  logic                      wready_s1,
  input  axi_pkg::axi_ids_t         bid_s1,
  input  axi_pkg::axi_resp_t        bresp_s1,
  input  logic                      bvalid_s1,
  output logic                      bready_s1,
  output axi_pkg::axi_data_t        wdata_s2,
  output axi_pkg::axi_strb_t        wstrb_s2,
  output logic                      wlast_s2,
  output logic                      wvalid_s2,
  input  logic                      wready_s2,
  input  axi_pkg::axi_ids_t         bid_s2,
  input  axi_pkg::axi_resp_t        bresp_s2,
  input  logic                      bvalid_s2,
  output logic                      bready_s2
);

  axi_pkg::addr_dec_result_t sel_q;
  axi_pkg::axi_ids_t         bid_m;
  logic                      open_q;

  assign b_done = b_valid & b_ready;
  // Drop the master prefix
  assign b_id   = axi_pkg::axi_id_t'(bid_m);

  // Target of the accepted address, kept until the response is taken
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      open_q <= 1'b0;
      sel_q  <= axi_pkg::SLAVE_2;
    end else if (aw_fire) begin
      open_q <= 1'b1;
      sel_q  <= aw_sel;
    end else if (b_done) begin
      open_q <= 1'b0;
      sel_q  <= axi_pkg::SLAVE_2;
    end
  end

  always_comb begin
    {wdata_s0, wdata_s1, wdata_s2}    = '0;
    {wstrb_s0, wstrb_s1, wstrb_s2}    = '0;
    {wlast_s0, wlast_s1, wlast_s2}    = '0;
    {wvalid_s0, wvalid_s1, wvalid_s2} = '0;
    {bready_s0, bready_s1, bready_s2} = '0;
    w_ready = 1'b0;
    b_valid = 1'b0;
    bid_m   = '0;
    b_resp  = axi_pkg::RESP_OKAY;
    if (open_q) begin
      case (sel_q)
        axi_pkg::SLAVE_0: begin
          {wdata_s0, wstrb_s0, wlast_s0, wvalid_s0} = {w_data, w_strb, w_last, w_valid};
          bready_s0 = b_ready;
          {w_ready, b_valid, bid_m, b_resp} = {wready_s0, bvalid_s0, bid_s0, bresp_s0};
        end
        axi_pkg::SLAVE_1: begin
          {wdata_s1, wstrb_s1, wlast_s1, wvalid_s1} = {w_data, w_strb, w_last, w_valid};
          bready_s1 = b_ready;
          {w_ready, b_valid, bid_m, b_resp} = {wready_s1, bvalid_s1, bid_s1, bresp_s1};
        end
        default: begin
          {wdata_s2, wstrb_s2, wlast_s2, wvalid_s2} = {w_data, w_strb, w_last, w_valid};
          bready_s2 = b_ready;
          {w_ready, b_valid, bid_m, b_resp} = {wready_s2, bvalid_s2, bid_s2, bresp_s2};
        end
      endcase
    end
  end

  // One write at a time across the whole crossbar
  a_single_open: assert property (@(posedge clk) disable iff (!rstn)
    aw_fire |-> !open_q);

endmodule

`default_nettype wire

// File: logic/axi_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module axi_reg_bank #(
  parameter int NUM_REGS = 4
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  axi_pkg::axi_ids_t       awid,
  input  axi_pkg::axi_addr_t      awaddr,
  input  axi_pkg::axi_len_t       awlen,
  input  axi_pkg::axi_burst_t     awburst,
  input  logic                    awvalid,
  output logic                    awready,
  input  axi_pkg::axi_data_t      wdata,
  input  axi_pkg::axi_strb_t      wstrb,
  input  logic                    wlast,
  input  logic                    wvalid,
  output logic                    wready,
  output axi_pkg::axi_ids_t       bid,
  output axi_pkg::axi_resp_t      bresp,
  output logic                    bvalid,
  input  logic                    bready,
  output logic [NUM_REGS*32-1:0]  regs
);

  axi_pkg::bank_state_t state;
  axi_pkg::axi_len_t    len_q;
  axi_pkg::axi_len_t    beat;
  logic [9:0]           off_q;
  logic [10:0]          idx;
  logic                 incr_q;
  logic                 err_q;
  logic                 w_hs;
  logic                 beat_ok;

  assign w_hs    = wvalid & wready;
  // Word index of the current beat
  assign idx     = {1'b0, off_q} + {3'b000, beat};
  assign beat_ok = incr_q && (idx < NUM_REGS);
  assign bresp   = err_q ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      bid    <= awid;
      len_q  <= awlen;
      off_q  <= awaddr[11:2];
      incr_q <= (awburst == axi_pkg::BURST_INCR);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= axi_pkg::BANK_IDLE;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      beat    <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state)
        axi_pkg::BANK_IDLE: begin
          if (awvalid && awready) begin
            state   <= axi_pkg::BANK_DATA;
            awready <= 1'b0;
            wready  <= 1'b1;
            beat    <= '0;
            err_q   <= 1'b0;
          end else begin
            awready <= 1'b1;
          end
        end
        axi_pkg::BANK_DATA: begin
          if (w_hs) begin
            beat  <= beat + 1'b1;
            // Dropped beat or wlast on the wrong beat
            err_q <= err_q | ~beat_ok | (wlast ^ (beat == len_q));
            if (wlast || beat == len_q) begin
              state  <= axi_pkg::BANK_RESP;
              wready <= 1'b0;
              bvalid <= 1'b1;
            end
          end
        end
        axi_pkg::BANK_RESP: begin
          if (bready) begin
            state   <= axi_pkg::BANK_IDLE;
            bvalid  <= 1'b0;
            awready <= 1'b1;
          end
        end
        default: state <= axi_pkg::BANK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      regs <= '0;
    end else if (w_hs && beat_ok) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb[b]) begin
          regs[idx*32 + b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  // Address must be held until this bank takes it
  a_aw_hold: assert property (@(posedge clk) disable iff (!rstn)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid));

endmodule

`default_nettype wire

// File: logic/axi_default_slave.sv
`timescale 1ns/1ps
`default_nettype none

module axi_default_slave (
  input  logic               clk,
  input  logic               rstn,
  input  axi_pkg::axi_ids_t  awid,
  input  logic               awvalid,
  output logic               awready,
  input  logic               wlast,
  input  logic               wvalid,
  output logic               wready,
  output axi_pkg::axi_ids_t  bid,
  output axi_pkg::axi_resp_t bresp,
  output logic               bvalid,
  input  logic               bready
);

  axi_pkg::bank_state_t state;

  // No target behind this address
  assign bresp = axi_pkg::RESP_DECERR;

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      bid <= awid;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= axi_pkg::BANK_IDLE;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      case (state)
        axi_pkg::BANK_IDLE: begin
          if (awvalid && awready) begin
            state   <= axi_pkg::BANK_DATA;
            awready <= 1'b0;
            wready  <= 1'b1;
          end else begin
            awready <= 1'b1;
          end
        end
        // Drain until wlast
        axi_pkg::BANK_DATA: begin
          if (wvalid && wready && wlast) begin
            state  <= axi_pkg::BANK_RESP;
            wready <= 1'b0;
            bvalid <= 1'b1;
          end
        end
        axi_pkg::BANK_RESP: begin
          if (bready) begin
            state   <= axi_pkg::BANK_IDLE;
            bvalid  <= 1'b0;
            awready <= 1'b1;
          end
        end
        default: state <= axi_pkg::BANK_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/axi_write_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_xbar #(
  parameter int NUM_REGS = 4
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  axi_pkg::axi_id_t       aw_id,
  input  axi_pkg::axi_addr_t     aw_addr,
  input  axi_pkg::axi_len_t      aw_len,
  input  axi_pkg::axi_size_t     aw_size,
  input  axi_pkg::axi_burst_t    aw_burst,
  input  logic                   aw_valid,
  output logic                   aw_ready,
  input  axi_pkg::axi_data_t     w_data,
  input  axi_pkg::axi_strb_t     w_strb,
  input  logic                   w_last,
  input  logic                   w_valid,
  output logic                   w_ready,
  output axi_pkg::axi_id_t       b_id,
  output axi_pkg::axi_resp_t     b_resp,
  output logic                   b_valid,
  input  logic                   b_ready,
  output logic [NUM_REGS*32-1:0] regs_s0,
  output logic [NUM_REGS*32-1:0] regs_s1
);

  axi_pkg::addr_dec_result_t aw_sel;
  logic                      aw_fire, b_done;
  axi_pkg::axi_ids_t         awid_s0, awid_s1, awid_s2;
  axi_pkg::axi_addr_t        awaddr_s0, awaddr_s1;
  axi_pkg::axi_len_t         awlen_s0, awlen_s1;
  axi_pkg::axi_burst_t       awburst_s0, awburst_s1;
  logic                      awvalid_s0, awvalid_s1, awvalid_s2;
  logic                      awready_s0, awready_s1, awready_s2;
  axi_pkg::axi_data_t        wdata_s0, wdata_s1;
  axi_pkg::axi_strb_t        wstrb_s0, wstrb_s1;
  logic                      wlast_s0, wlast_s1, wlast_s2;
  logic                      wvalid_s0, wvalid_s1, wvalid_s2;
  logic                      wready_s0, wready_s1, wready_s2;
  axi_pkg::axi_ids_t         bid_s0, bid_s1, bid_s2;
  axi_pkg::axi_resp_t        bresp_s0, bresp_s1, bresp_s2;
  logic                      bvalid_s0, bvalid_s1, bvalid_s2;
  logic                      bready_s0, bready_s1, bready_s2;

  // Default slave ignores address, size and data
  aw_router u_aw_router (
    .clk, .rstn, .aw_id, .aw_addr, .aw_len, .aw_size, .aw_burst, .aw_valid, .aw_ready,
    .b_done, .awready_s0, .awready_s1, .awready_s2,
    .awid_s0, .awaddr_s0, .awlen_s0, .awsize_s0(), .awburst_s0, .awvalid_s0,
    .awid_s1, .awaddr_s1, .awlen_s1, .awsize_s1(), .awburst_s1, .awvalid_s1,
    .awid_s2, .awaddr_s2(), .awlen_s2(), .awsize_s2(), .awburst_s2(), .awvalid_s2,
    .aw_sel, .aw_fire
  );

  wb_router u_wb_router (
    .clk, .rstn, .aw_sel, .aw_fire, .w_data, .w_strb, .w_last, .w_valid, .w_ready,
    .b_id, .b_resp, .b_valid, .b_ready, .b_done,
    .wdata_s0, .wstrb_s0, .wlast_s0, .wvalid_s0, .wready_s0,
    .bid_s0, .bresp_s0, .bvalid_s0, .bready_s0,
    .wdata_s1, .wstrb_s1, .wlast_s1, .wvalid_s1, .wready_s1,
    .bid_s1, .bresp_s1, .bvalid_s1, .bready_s1,
    .wdata_s2(), .wstrb_s2(), .wlast_s2, .wvalid_s2, .wready_s2,
    .bid_s2, .bresp_s2, .bvalid_s2, .bready_s2
  );

  axi_reg_bank #(.NUM_REGS(NUM_REGS)) u_bank0 (
    .clk, .rstn, .awid(awid_s0), .awaddr(awaddr_s0), .awlen(awlen_s0),
    .awburst(awburst_s0), .awvalid(awvalid_s0), .awready(awready_s0),
    .wdata(wdata_s0), .wstrb(wstrb_s0), .wlast(wlast_s0), .wvalid(wvalid_s0),
    .wready(wready_s0), .bid(bid_s0), .bresp(bresp_s0), .bvalid(bvalid_s0),
    .bready(bready_s0), .regs(regs_s0)
  );

  axi_reg_bank #(.NUM_REGS(NUM_REGS)) u_bank1 (
    .clk, .rstn, .awid(awid_s1), .awaddr(awaddr_s1), .awlen(awlen_s1),
    .awburst(awburst_s1), .awvalid(awvalid_s1), .awready(awready_s1),
    .wdata(wdata_s1), .wstrb(wstrb_s1), .wlast(wlast_s1), .wvalid(wvalid_s1),
    .wready(wready_s1), .bid(bid_s1), .bresp(bresp_s1), .bvalid(bvalid_s1),
    .bready(bready_s1), .regs(regs_s1)
  );

  axi_default_slave u_default_slave (
    .clk, .rstn, .awid(awid_s2), .awvalid(awvalid_s2), .awready(awready_s2),
    .wlast(wlast_s2), .wvalid(wvalid_s2), .wready(wready_s2),
    .bid(bid_s2), .bresp(bresp_s2), .bvalid(bvalid_s2), .bready(bready_s2)
  );

endmodule

`default_nettype wire

// File: verif/tb_axi_write_xbar.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_write_xbar;

  localparam int NUM_REGS  = 4;
  localparam int MAX_TESTS = 64;
  localparam int HS_LIMIT  = 32;
  localparam int CH_AW     = 0;
  localparam int CH_W      = 1;
  localparam int CH_B      = 2;

  logic                     clk;
  logic                     rstn;
  axi_pkg::axi_id_t         aw_id;
  axi_pkg::axi_addr_t       aw_addr;
  axi_pkg::axi_len_t        aw_len;
  axi_pkg::axi_size_t       aw_size;
  axi_pkg::axi_burst_t      aw_burst;
  logic                     aw_valid;
  logic                     aw_ready;
  axi_pkg::axi_data_t       w_data;
  axi_pkg::axi_strb_t       w_strb;
  logic                     w_last;
  logic                     w_valid;
  logic                     w_ready;
  axi_pkg::axi_id_t         b_id;
  axi_pkg::axi_resp_t       b_resp;
  logic                     b_valid;
  logic                     b_ready;
  logic [NUM_REGS*32-1:0]   regs_s0;
  logic [NUM_REGS*32-1:0]   regs_s1;

  // Test table, one entry per line of the test file
  string                    t_name  [MAX_TESTS];
  axi_pkg::axi_id_t         t_id    [MAX_TESTS];
  axi_pkg::axi_addr_t       t_addr  [MAX_TESTS];
  axi_pkg::axi_len_t        t_len   [MAX_TESTS];
  axi_pkg::axi_burst_t      t_burst [MAX_TESTS];
  axi_pkg::axi_data_t       t_data  [MAX_TESTS][4];
  axi_pkg::axi_strb_t       t_strb  [MAX_TESTS][4];
  axi_pkg::axi_resp_t       t_resp  [MAX_TESTS];
  logic [NUM_REGS*32-1:0]   t_regs0 [MAX_TESTS];
  logic [NUM_REGS*32-1:0]   t_regs1 [MAX_TESTS];
  int                       num_tests;
  logic                     loaded;
  int                       value_errors;
  int                       flow_errors;

  axi_write_xbar #(.NUM_REGS(NUM_REGS)) u_axi_write_xbar (
    .clk, .rstn, .aw_id, .aw_addr, .aw_len, .aw_size, .aw_burst, .aw_valid, .aw_ready,
    .w_data, .w_strb, .w_last, .w_valid, .w_ready,
    .b_id, .b_resp, .b_valid, .b_ready, .regs_s0, .regs_s1
  );

  always #2 clk = ~clk;

  task automatic load_tests();
    int                     fd;
    int                     n;
    string                  line;
    string                  name;
    logic [31:0]            f [13];
    logic [NUM_REGS*32-1:0] img0;
    logic [NUM_REGS*32-1:0] img1;
    fd = $fopen("verif/write_tests.txt", "r");
    if (fd == 0) begin
      flow_errors++;
      $display("Cannot open verif/write_tests.txt");
      return;
    end
    while (!$feof(fd) && num_tests < MAX_TESTS) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                  f[11], f[12], img0, img1);
      if (n != 16 || f[2] > 3) begin
        flow_errors++;
        $display("Malformed line in test file: %s", line);
        continue;
      end
      t_name[num_tests]  = name;
      t_id[num_tests]    = f[0][3:0];
      t_addr[num_tests]  = f[1];
      t_len[num_tests]   = f[2][7:0];
      t_burst[num_tests] = f[3][1:0];
      for (int k = 0; k < 4; k++) begin
        t_data[num_tests][k] = f[4+2*k];
        t_strb[num_tests][k] = f[5+2*k][3:0];
      end
      t_resp[num_tests]  = f[12][1:0];
      t_regs0[num_tests] = img0;
      t_regs1[num_tests] = img1;
      num_tests++;
    end
    $fclose(fd);
  endtask

  task automatic check_resp(input string test, input axi_pkg::axi_resp_t expected,
                            input axi_pkg::axi_resp_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAILED %s: b_resp expected %0d, actual %0d", test, expected, actual);
    end
  endtask

  task automatic check_id(input string test, input axi_pkg::axi_id_t expected,
                          input axi_pkg::axi_id_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAILED %s: b_id expected %h, actual %h", test, expected, actual);
    end
  endtask

  task automatic check_regs(input string test, input string which,
                            input logic [NUM_REGS*32-1:0] expected,
                            input logic [NUM_REGS*32-1:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAILED %s: %s expected %h, actual %h", test, which, expected, actual);
    end
  endtask

  // Samples on the falling edge, returns there with the ready/valid seen
  task automatic wait_for_ready(input int ch, input string test);
    int    cycles;
    logic  seen;
    string what;
    cycles = 0;
    seen   = 1'b0;
    what   = (ch == CH_AW) ? "aw_ready" : (ch == CH_W) ? "w_ready" : "b_valid";
    while (!seen && cycles < HS_LIMIT) begin
      @(negedge clk);
      case (ch)
        CH_AW:   seen = aw_ready;
        CH_W:    seen = w_ready;
        default: seen = b_valid;
      endcase
      cycles++;
    end
    if (!seen) begin
      flow_errors++;
      $display("Test %s: %s never came within %0d cycles", test, what, HS_LIMIT);
    end
  endtask

  task automatic drive_aw(input int i);
    aw_id    <= t_id[i];
    aw_addr  <= t_addr[i];
    aw_len   <= t_len[i];
    aw_size  <= 3'd2;
    aw_burst <= t_burst[i];
    aw_valid <= 1'b1;
  endtask

  task automatic run_test(input int i);
    int gap;
    int stall;
    gap   = $urandom % 4;
    stall = $urandom % 6;
    if (aw_valid) begin
      // Address already offered while the last response was held
      if (!aw_ready) begin
        wait_for_ready(CH_AW, t_name[i]);
      end
    end else begin
      repeat (gap) @(posedge clk);
      @(posedge clk);
      drive_aw(i);
      wait_for_ready(CH_AW, t_name[i]);
    end
    for (int k = 0; k <= int'(t_len[i]); k++) begin
      @(posedge clk);
      aw_valid <= 1'b0;
      w_data   <= t_data[i][k];
      w_strb   <= t_strb[i][k];
      w_last   <= (k == int'(t_len[i]));
      w_valid  <= 1'b1;
      wait_for_ready(CH_W, t_name[i]);
    end
    @(posedge clk);
    w_valid <= 1'b0;
    w_last  <= 1'b0;
    wait_for_ready(CH_B, t_name[i]);
    check_resp(t_name[i], t_resp[i], b_resp);
    check_id(t_name[i], t_id[i], b_id);
    // Next address has to wait behind the held response
    if (stall != 0 && i + 1 < num_tests) begin
      @(posedge clk);
      drive_aw(i + 1);
    end
    // Response must hold under back-pressure
    repeat (stall) begin
      @(negedge clk);
      if (!b_valid) begin
        flow_errors++;
        $display("Test %s: b_valid dropped while b_ready was low", t_name[i]);
      end
      if (aw_ready) begin
        flow_errors++;
        $display("Test %s: aw_ready rose before the response was taken", t_name[i]);
      end
      check_resp(t_name[i], t_resp[i], b_resp);
      check_id(t_name[i], t_id[i], b_id);
    end
    @(posedge clk);
    b_ready <= 1'b1;
    @(negedge clk);
    if (!b_valid) begin
      flow_errors++;
      $display("Test %s: b_valid was gone when b_ready rose", t_name[i]);
    end
    if (aw_ready) begin
      flow_errors++;
      $display("Test %s: aw_ready rose in the cycle of the response", t_name[i]);
    end
    @(posedge clk);
    b_ready <= 1'b0;
    @(negedge clk);
    check_regs(t_name[i], "regs_s0", t_regs0[i], regs_s0);
    check_regs(t_name[i], "regs_s1", t_regs1[i], regs_s1);
  endtask

  initial begin
    clk          = 1'b0;
    rstn         = 1'b0;
    aw_id        = '0;
    aw_addr      = '0;
    aw_len       = '0;
    aw_size      = '0;
    aw_burst     = '0;
    aw_valid     = 1'b0;
    w_data       = '0;
    w_strb       = '0;
    w_last       = 1'b0;
    w_valid      = 1'b0;
    b_ready      = 1'b0;
    value_errors = 0;
    flow_errors  = 0;
    num_tests    = 0;
    loaded       = 1'b0;
    void'($urandom(32'hbe02b99d));
    load_tests();
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    if (aw_ready) begin
      flow_errors++;
      $display("aw_ready was high after reset without aw_valid");
    end
    if (num_tests == 0) begin
      flow_errors++;
      $display("No tests were loaded");
    end
    for (int i = 0; i < num_tests; i++) begin
      run_test(i);
    end
    repeat (4) @(posedge clk);
    $display("Errors: %0d value mismatches, %0d handshake or file errors",
             value_errors, flow_errors);
    if (value_errors == 0 && flow_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    int limit;
    wait (loaded);
    limit = num_tests * 64 + 100;
    repeat (limit) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/write_tests.txt
# name id addr len burst d0 s0 d1 s1 d2 s2 d3 s3 resp regs_s0 regs_s1 (all hex, unused beats 0)
# burst 0 FIXED 1 INCR 2 WRAP; resp 0 OKAY 2 SLVERR 3 DECERR; images are reg3..reg0
single_b0 3 00000004 0 1 11223344 f 00000000 0 00000000 0 00000000 0 0 00000000000000001122334400000000 00000000000000000000000000000000
single_b1 5 0000100c 0 1 a5a5a5a5 f 00000000 0 00000000 0 00000000 0 0 00000000000000001122334400000000 a5a5a5a5000000000000000000000000
burst_b0 7 00000000 3 1 deadbeef f 12345678 3 cafef00d c 99887766 5 0 00880066cafe000011225678deadbeef a5a5a5a5000000000000000000000000
decerr_low 9 00002000 1 1 ffffffff f ffffffff f 00000000 0 00000000 0 3 00880066cafe000011225678deadbeef a5a5a5a5000000000000000000000000
past_end_b1 2 00001008 3 1 01010101 f 02020202 f 03030303 f 04040404 f 2 00880066cafe000011225678deadbeef 02020202010101010000000000000000
fixed_b0 c 00000008 1 0 77777777 f 88888888 f 00000000 0 00000000 0 2 00880066cafe000011225678deadbeef 02020202010101010000000000000000
strobe_b0 f 0000000c 0 1 abcdef01 2 00000000 0 00000000 0 00000000 0 0 0088ef66cafe000011225678deadbeef 02020202010101010000000000000000
pair_b1 1 00001000 1 1 55aa55aa f 0f0f0f0f 1 00000000 0 00000000 0 0 0088ef66cafe000011225678deadbeef 02020202010101010000000f55aa55aa
decerr_high 6 80000000 0 1 12345678 f 00000000 0 00000000 0 00000000 0 3 0088ef66cafe000011225678deadbeef 02020202010101010000000f55aa55aa
wrap_b1 4 00001004 1 2 ffffffff f ffffffff f 00000000 0 00000000 0 2 0088ef66cafe000011225678deadbeef 02020202010101010000000f55aa55aa
burst_b1 e 00001000 3 1 10000001 f 20000002 f 30000003 f 40000004 f 0 0088ef66cafe000011225678deadbeef 40000004300000032000000210000001
top_byte_b0 a 00000000 0 1 7f000000 8 00000000 0 00000000 0 00000000 0 0 0088ef66cafe0000112256787fadbeef 40000004300000032000000210000001
past_end_b0 b 0000000c 1 1 0badf00d f 00000001 f 00000000 0 00000000 0 2 0badf00dcafe0000112256787fadbeef 40000004300000032000000210000001

// File: verilog.f
logic/axi_pkg.sv
logic/aw_router.sv
logic/wb_router.sv
logic/axi_reg_bank.sv
logic/axi_default_slave.sv
logic/axi_write_xbar.sv
verif/tb_axi_write_xbar.sv

// File: Bender.yml
package:
  name: axi_write_xbar

sources:
  - logic/axi_pkg.sv
  - logic/aw_router.sv
  - logic/wb_router.sv
  - logic/axi_reg_bank.sv
  - logic/axi_default_slave.sv
  - logic/axi_write_xbar.sv
  - target: test
    files:
      - verif/tb_axi_write_xbar.sv
